// ==== xv_params.svh ====
`ifndef XV_PARAMS_SVH
`define XV_PARAMS_SVH

// word address width of each color bank
`define XV_COLOR_AWIDTH 8

// word address width of tile memory
`define XV_TILE_AWIDTH 10

// copper entry address, the half bit excluded
`define XV_COPPER_AWIDTH 8

// address bits 15:13 of each memory region
`define XV_REGION_COLOR 3'b100
`define XV_REGION_TILE 3'b101
`define XV_REGION_COPPER 3'b110

// color bank B lives at offset 0x100 of the color region,
// so the bank select is the bit just above the bank address.
// copper entries are split by address bit 0 into even and odd halves,
// even half first as the host sees it

`endif

// ==== xv_pkg.sv ====
`include "xv_params.svh"

package xv_pkg;

    typedef logic [15:0] xr_word_t;
    typedef logic [15:0] xr_addr_t;

    // where an XR address lands
    typedef enum logic [2:0] {
        REG_BUS,
        COLOR,
        TILE,
        COPPER,
        UNMAPPED
    } xr_region_e;

    function automatic xr_region_e xr_decode_region(input xr_addr_t addr);
        xr_region_e region;
        case (addr[15:13])
            `XV_REGION_COLOR: region = COLOR;
            `XV_REGION_TILE: region = TILE;
            `XV_REGION_COPPER: region = COPPER;
            3'b111: region = UNMAPPED;
            // bit 15 clear, external register file
            default: region = REG_BUS;
        endcase
        return region;
    endfunction

endpackage

// ==== xr_bus_if.sv ====
`timescale 1ns/1ps
`include "xv_params.svh"

// write path from the write arbiter to the memories
interface xr_wr_if import xv_pkg::*; ();
    logic     wr_color_a;
    logic     wr_color_b;
    logic     wr_tile;
    logic     wr_copp_even;
    logic     wr_copp_odd;
    xr_addr_t wr_addr;
    xr_word_t wr_data;
    logic     copp_grant;
    logic     host_wr_grant;
    // registered acks coming back
    logic     xr_ack;
    logic     copp_ack;

    modport arb (
        output wr_color_a, wr_color_b, wr_tile, wr_copp_even, wr_copp_odd,
        output wr_addr, wr_data, copp_grant, host_wr_grant,
        input  xr_ack, copp_ack
    );

    modport mem (
        input  wr_color_a, wr_color_b, wr_tile, wr_copp_even, wr_copp_odd,
        input  wr_addr, wr_data, copp_grant, host_wr_grant,
        output xr_ack, copp_ack
    );
endinterface

// read ports of the three memories plus the host read routing
interface xr_rd_if import xv_pkg::*; ();
    logic                          color_rd_en;
    logic [`XV_COLOR_AWIDTH-1:0]   color_rd_addr;
    logic [`XV_COLOR_AWIDTH-1:0]   color_b_rd_addr;
    logic                          tile_rd_en;
    logic [`XV_TILE_AWIDTH-1:0]    tile_rd_addr;
    logic                          copp_rd_en;
    logic [`XV_COPPER_AWIDTH-1:0]  copp_rd_addr;
    logic                          host_rd_grant;
    xr_region_e                    host_rd_region;
    // bank B or odd copper half
    logic                          host_rd_sel_hi;
    logic                          xr_ack;
    logic                          copp_ack;

    modport arb (
        output color_rd_en, color_rd_addr, color_b_rd_addr,
        output tile_rd_en, tile_rd_addr, copp_rd_en, copp_rd_addr,
        output host_rd_grant, host_rd_region, host_rd_sel_hi,
        input  xr_ack, copp_ack
    );

    modport mem (
        input  color_rd_en, color_rd_addr, color_b_rd_addr,
        input  tile_rd_en, tile_rd_addr, copp_rd_en, copp_rd_addr,
        input  host_rd_grant, host_rd_region, host_rd_sel_hi,
        output xr_ack, copp_ack
    );
endinterface

// ==== xr_ram.sv ====
`timescale 1ns/1ps

module xr_ram #(
    parameter int AWIDTH = 8
) (
    input  logic              clk,
    input  logic              rd_en_i,
    input  logic [AWIDTH-1:0] rd_addr_i,
    input  logic              wr_en_i,
    input  logic [AWIDTH-1:0] wr_addr_i,
    input  logic [15:0]       wr_data_i,
    output logic [15:0]       rd_data_o
);

    // starts out cleared
    logic [15:0] mem [2**AWIDTH] = '{default: '0};

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // registered read, output held between reads
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// ==== xr_write_arb.sv ====
`timescale 1ns/1ps
`include "xv_params.svh"

module xr_write_arb import xv_pkg::*; (
    input  logic     xr_sel_i,
    input  logic     xr_wr_i,
    input  xr_addr_t xr_addr_i,
    input  xr_word_t xr_data_i,
    input  logic     copp_xr_sel_i,
    input  xr_addr_t copp_xr_addr_i,
    input  xr_word_t copp_xr_data_i,
    output logic     xreg_wr_o,
    output xr_addr_t xreg_addr_o,
    output xr_word_t xreg_data_o,
    xr_wr_if.arb     wr
);

    logic       copp_pend;
    logic       host_pend;
    logic       any_grant;
    xr_addr_t   sel_addr;
    xr_word_t   sel_data;
    xr_region_e sel_region;

    // pending means select high and not yet acknowledged
    assign copp_pend = copp_xr_sel_i & ~wr.copp_ack;
    // host waits for any pending copper write
    assign host_pend = xr_sel_i & xr_wr_i & ~wr.xr_ack & ~copp_pend;

    assign wr.copp_grant    = copp_pend;
    assign wr.host_wr_grant = host_pend;
    assign any_grant        = copp_pend | host_pend;

    // copper owns the shared write path when it asks
    assign sel_addr   = copp_pend ? copp_xr_addr_i : xr_addr_i;
    assign sel_data   = copp_pend ? copp_xr_data_i : xr_data_i;
    assign sel_region = xr_decode_region(sel_addr);

    assign wr.wr_addr   = sel_addr;
    assign wr.wr_data   = sel_data;
    assign xreg_addr_o  = sel_addr;
    assign xreg_data_o  = sel_data;

    // one strobe per granted write
    always_comb begin
        wr.wr_color_a   = 1'b0;
        wr.wr_color_b   = 1'b0;
        wr.wr_tile      = 1'b0;
        wr.wr_copp_even = 1'b0;
        wr.wr_copp_odd  = 1'b0;
        xreg_wr_o       = 1'b0;
        if (any_grant) begin
            case (sel_region)
                REG_BUS: begin
                    xreg_wr_o = 1'b1;
                end
                COLOR: begin
                    wr.wr_color_a = ~sel_addr[`XV_COLOR_AWIDTH];
                    wr.wr_color_b = sel_addr[`XV_COLOR_AWIDTH];
                end
                TILE: begin
                    wr.wr_tile = 1'b1;
                end
                COPPER: begin
                    wr.wr_copp_even = ~sel_addr[0];
                    wr.wr_copp_odd  = sel_addr[0];
                end
                default: begin
                    // unmapped, only the ack happens
                    xreg_wr_o = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== xr_read_arb.sv ====
`timescale 1ns/1ps
`include "xv_params.svh"

module xr_read_arb import xv_pkg::*; (
    input  logic                          xr_sel_i,
    input  logic                          xr_wr_i,
    input  xr_addr_t                      xr_addr_i,
    input  logic                          copp_xr_sel_i,
    input  logic                          vgen_color_sel_i,
    input  logic [`XV_COLOR_AWIDTH-1:0]   vgen_color_a_addr_i,
    input  logic [`XV_COLOR_AWIDTH-1:0]   vgen_color_b_addr_i,
    input  logic                          vgen_tile_sel_i,
    input  logic [`XV_TILE_AWIDTH-1:0]    vgen_tile_addr_i,
    input  logic                          copp_prog_sel_i,
    input  logic [`XV_COPPER_AWIDTH-1:0]  copp_prog_addr_i,
    xr_rd_if.arb                          rd
);

    logic       copp_pend;
    logic       host_pend;
    logic       color_host;
    logic       tile_host;
    logic       copp_host;
    logic       no_mem_host;
    xr_region_e host_region;

    // a pending copper write holds off host reads
    assign copp_pend   = copp_xr_sel_i & ~rd.copp_ack;
    assign host_pend   = xr_sel_i & ~xr_wr_i & ~rd.xr_ack & ~copp_pend;
    assign host_region = xr_decode_region(xr_addr_i);

    // color banks, video first
    always_comb begin
        rd.color_rd_en   = vgen_color_sel_i;
        rd.color_rd_addr = vgen_color_a_addr_i;
        color_host       = 1'b0;
        if (!vgen_color_sel_i && host_pend && host_region == COLOR) begin
            color_host       = 1'b1;
            rd.color_rd_en   = 1'b1;
            rd.color_rd_addr = xr_addr_i[`XV_COLOR_AWIDTH-1:0];
        end
    end

    // bank B follows bank A in the combiner when the host reads
    assign rd.color_b_rd_addr = vgen_color_b_addr_i;

    // tile memory, video first
    always_comb begin
        rd.tile_rd_en   = vgen_tile_sel_i;
        rd.tile_rd_addr = vgen_tile_addr_i;
        tile_host       = 1'b0;
        if (!vgen_tile_sel_i && host_pend && host_region == TILE) begin
            tile_host       = 1'b1;
            rd.tile_rd_en   = 1'b1;
            rd.tile_rd_addr = xr_addr_i[`XV_TILE_AWIDTH-1:0];
        end
    end

    // copper memory, program fetch first
    always_comb begin
        rd.copp_rd_en   = copp_prog_sel_i;
        rd.copp_rd_addr = copp_prog_addr_i;
        copp_host       = 1'b0;
        if (!copp_prog_sel_i && host_pend && host_region == COPPER) begin
            copp_host       = 1'b1;
            rd.copp_rd_en   = 1'b1;
            rd.copp_rd_addr = xr_addr_i[`XV_COPPER_AWIDTH:1];
        end
    end

    // register bus and unmapped reads never wait on a RAM port
    assign no_mem_host = host_pend & (host_region == REG_BUS || host_region == UNMAPPED);

    assign rd.host_rd_grant  = color_host | tile_host | copp_host | no_mem_host;
    assign rd.host_rd_region = host_region;
    assign rd.host_rd_sel_hi = (host_region == COLOR) ? xr_addr_i[`XV_COLOR_AWIDTH]
                                                      : xr_addr_i[0];

endmodule

// ==== xrmem_arb.sv ====
`timescale 1ns/1ps
`include "xv_params.svh"

module xrmem_arb import xv_pkg::*; (
    input  logic        clk,
    input  logic        rst_i,
    input  xr_word_t    xreg_data_i,
    xr_wr_if.mem        wr,
    xr_rd_if.mem        rd,
    output xr_word_t    xr_data_o,
    output xr_word_t    vgen_color_a_data_o,
    output xr_word_t    vgen_color_b_data_o,
    output xr_word_t    vgen_tile_data_o,
    output logic [31:0] copp_prog_data_o
);

    logic                        xr_ack_q;
    logic                        copp_ack_q;
    xr_region_e                  rd_region_q;
    logic                        rd_sel_hi_q;
    logic                        host_color;
    logic [`XV_COLOR_AWIDTH-1:0] color_b_addr;
    xr_word_t                    color_a_q;
    xr_word_t                    color_b_q;
    xr_word_t                    tile_q;
    xr_word_t                    copp_even_q;
    xr_word_t                    copp_odd_q;

    // host reads both banks at the same word
    assign host_color   = rd.host_rd_grant && rd.host_rd_region == COLOR;
    assign color_b_addr = host_color ? rd.color_rd_addr : rd.color_b_rd_addr;

    xr_ram #(.AWIDTH(`XV_COLOR_AWIDTH)) u_color_a (
        .clk       (clk),
        .rd_en_i   (rd.color_rd_en),
        .rd_addr_i (rd.color_rd_addr),
        .wr_en_i   (wr.wr_color_a),
        .wr_addr_i (wr.wr_addr[`XV_COLOR_AWIDTH-1:0]),
        .wr_data_i (wr.wr_data),
        .rd_data_o (color_a_q)
    );

    xr_ram #(.AWIDTH(`XV_COLOR_AWIDTH)) u_color_b (
        .clk       (clk),
        .rd_en_i   (rd.color_rd_en),
        .rd_addr_i (color_b_addr),
        .wr_en_i   (wr.wr_color_b),
        .wr_addr_i (wr.wr_addr[`XV_COLOR_AWIDTH-1:0]),
        .wr_data_i (wr.wr_data),
        .rd_data_o (color_b_q)
    );

    xr_ram #(.AWIDTH(`XV_TILE_AWIDTH)) u_tile (
        .clk       (clk),
        .rd_en_i   (rd.tile_rd_en),
        .rd_addr_i (rd.tile_rd_addr),
        .wr_en_i   (wr.wr_tile),
        .wr_addr_i (wr.wr_addr[`XV_TILE_AWIDTH-1:0]),
        .wr_data_i (wr.wr_data),
        .rd_data_o (tile_q)
    );

    // copper halves share one entry address
    xr_ram #(.AWIDTH(`XV_COPPER_AWIDTH)) u_copp_even (
        .clk       (clk),
        .rd_en_i   (rd.copp_rd_en),
        .rd_addr_i (rd.copp_rd_addr),
        .wr_en_i   (wr.wr_copp_even),
        .wr_addr_i (wr.wr_addr[`XV_COPPER_AWIDTH:1]),
        .wr_data_i (wr.wr_data),
        .rd_data_o (copp_even_q)
    );

    xr_ram #(.AWIDTH(`XV_COPPER_AWIDTH)) u_copp_odd (
        .clk       (clk),
        .rd_en_i   (rd.copp_rd_en),
        .rd_addr_i (rd.copp_rd_addr),
        .wr_en_i   (wr.wr_copp_odd),
        .wr_addr_i (wr.wr_addr[`XV_COPPER_AWIDTH:1]),
        .wr_data_i (wr.wr_data),
        .rd_data_o (copp_odd_q)
    );

    // acks pulse the cycle after a grant
    always_ff @(posedge clk) begin
        if (rst_i) begin
            xr_ack_q   <= 1'b0;
            copp_ack_q <= 1'b0;
        end else begin
            xr_ack_q   <= wr.host_wr_grant | rd.host_rd_grant;
            copp_ack_q <= wr.copp_grant;
        end
    end

    // routing for the host read word in the ack cycle
    always_ff @(posedge clk) begin
        rd_region_q <= rd.host_rd_region;
        rd_sel_hi_q <= rd.host_rd_sel_hi;
    end

    assign wr.xr_ack   = xr_ack_q;
    assign wr.copp_ack = copp_ack_q;
    assign rd.xr_ack   = xr_ack_q;
    assign rd.copp_ack = copp_ack_q;

    always_comb begin
        case (rd_region_q)
            REG_BUS: xr_data_o = xreg_data_i;
            COLOR: xr_data_o = rd_sel_hi_q ? color_b_q : color_a_q;
            TILE: xr_data_o = tile_q;
            COPPER: xr_data_o = rd_sel_hi_q ? copp_odd_q : copp_even_q;
            // unmapped reads as zero
            default: xr_data_o = '0;
        endcase
    end

    assign vgen_color_a_data_o = color_a_q;
    assign vgen_color_b_data_o = color_b_q;
    assign vgen_tile_data_o    = tile_q;
    // even half in the upper word
    assign copp_prog_data_o    = {copp_even_q, copp_odd_q};

endmodule

// ==== xrmem_top.sv ====
`timescale 1ns/1ps
`include "xv_params.svh"

module xrmem_top (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          xr_sel_i,
    output logic                          xr_ack_o,
    input  logic                          xr_wr_i,
    input  logic [15:0]                   xr_addr_i,
    input  logic [15:0]                   xr_data_i,
    output logic [15:0]                   xr_data_o,
    input  logic                          copp_xr_sel_i,
    output logic                          copp_xr_ack_o,
    input  logic [15:0]                   copp_xr_addr_i,
    input  logic [15:0]                   copp_xr_data_i,
    output logic                          xreg_wr_o,
    output logic [15:0]                   xreg_addr_o,
    output logic [15:0]                   xreg_data_o,
    input  logic [15:0]                   xreg_data_i,
    input  logic                          vgen_color_sel_i,
    input  logic [`XV_COLOR_AWIDTH-1:0]   vgen_color_a_addr_i,
    input  logic [`XV_COLOR_AWIDTH-1:0]   vgen_color_b_addr_i,
    output logic [15:0]                   vgen_color_a_data_o,
    output logic [15:0]                   vgen_color_b_data_o,
    input  logic                          vgen_tile_sel_i,
    input  logic [`XV_TILE_AWIDTH-1:0]    vgen_tile_addr_i,
    output logic [15:0]                   vgen_tile_data_o,
    input  logic                          copp_prog_sel_i,
    input  logic [`XV_COPPER_AWIDTH-1:0]  copp_prog_addr_i,
    output logic [31:0]                   copp_prog_data_o
);

    xr_wr_if u_wr_if ();
    xr_rd_if u_rd_if ();

    // write and read arbitration run side by side
    xr_write_arb u_write_arb (
        .xr_sel_i       (xr_sel_i),
        .xr_wr_i        (xr_wr_i),
        .xr_addr_i      (xr_addr_i),
        .xr_data_i      (xr_data_i),
        .copp_xr_sel_i  (copp_xr_sel_i),
        .copp_xr_addr_i (copp_xr_addr_i),
        .copp_xr_data_i (copp_xr_data_i),
        .xreg_wr_o      (xreg_wr_o),
        .xreg_addr_o    (xreg_addr_o),
        .xreg_data_o    (xreg_data_o),
        .wr             (u_wr_if.arb)
    );

    xr_read_arb u_read_arb (
        .xr_sel_i            (xr_sel_i),
        .xr_wr_i             (xr_wr_i),
        .xr_addr_i           (xr_addr_i),
        .copp_xr_sel_i       (copp_xr_sel_i),
        .vgen_color_sel_i    (vgen_color_sel_i),
        .vgen_color_a_addr_i (vgen_color_a_addr_i),
        .vgen_color_b_addr_i (vgen_color_b_addr_i),
        .vgen_tile_sel_i     (vgen_tile_sel_i),
        .vgen_tile_addr_i    (vgen_tile_addr_i),
        .copp_prog_sel_i     (copp_prog_sel_i),
        .copp_prog_addr_i    (copp_prog_addr_i),
        .rd                  (u_rd_if.arb)
    );

    xrmem_arb u_mem_arb (
        .clk                 (clk),
        .rst_i               (rst_i),
        .xreg_data_i         (xreg_data_i),
        .wr                  (u_wr_if.mem),
        .rd                  (u_rd_if.mem),
        .xr_data_o           (xr_data_o),
        .vgen_color_a_data_o (vgen_color_a_data_o),
        .vgen_color_b_data_o (vgen_color_b_data_o),
        .vgen_tile_data_o    (vgen_tile_data_o),
        .copp_prog_data_o    (copp_prog_data_o)
    );

    // acks come straight from the combiner registers
    assign xr_ack_o      = u_wr_if.xr_ack;
    assign copp_xr_ack_o = u_wr_if.copp_ack;

endmodule

// ==== tb_xrmem_top.sv ====
`timescale 1ns/1ps
`include "xv_params.svh"

module tb_xrmem_top import xv_pkg::*; ();

    logic                         clk;
    logic                         rst_i;
    logic                         xr_sel_i;
    logic                         xr_ack_o;
    logic                         xr_wr_i;
    logic [15:0]                  xr_addr_i;
    logic [15:0]                  xr_data_i;
    logic [15:0]                  xr_data_o;
    logic                         copp_xr_sel_i;
    logic                         copp_xr_ack_o;
    logic [15:0]                  copp_xr_addr_i;
    logic [15:0]                  copp_xr_data_i;
    logic                         xreg_wr_o;
    logic [15:0]                  xreg_addr_o;
    logic [15:0]                  xreg_data_o;
    logic [15:0]                  xreg_data_i;
    logic                         vgen_color_sel_i;
    logic [`XV_COLOR_AWIDTH-1:0]  vgen_color_a_addr_i;
    logic [`XV_COLOR_AWIDTH-1:0]  vgen_color_b_addr_i;
    logic [15:0]                  vgen_color_a_data_o;
    logic [15:0]                  vgen_color_b_data_o;
    logic                         vgen_tile_sel_i;
    logic [`XV_TILE_AWIDTH-1:0]   vgen_tile_addr_i;
    logic [15:0]                  vgen_tile_data_o;
    logic                         copp_prog_sel_i;
    logic [`XV_COPPER_AWIDTH-1:0] copp_prog_addr_i;
    logic [31:0]                  copp_prog_data_o;

    // shadow copies of every memory
    xr_word_t shadow_color_a [256];
    xr_word_t shadow_color_b [256];
    xr_word_t shadow_tile [1024];
    xr_word_t shadow_copp_even [256];
    xr_word_t shadow_copp_odd [256];
    xr_word_t reg_model [256];

    int   errors = 0;
    int   tests_run = 0;
    int   tests_bad = 0;
    logic timed_out = 1'b0;

    xrmem_top u_xrmem_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // external register file, read combinationally at the forwarded address
    assign xreg_data_i = reg_model[xreg_addr_o[7:0]];

    always @(posedge clk) begin
        if (xreg_wr_o) begin
            reg_model[xreg_addr_o[7:0]] <= xreg_data_o;
        end
    end

    function automatic xr_word_t reg_fill(input logic [7:0] a);
        return {a, ~a};
    endfunction

    // predicted host read of a memory address
    function automatic xr_word_t expected_word(input logic [15:0] addr);
        xr_word_t word;
        word = 16'h0000;
        if (addr[15:13] == `XV_REGION_COLOR) begin
            word = addr[8] ? shadow_color_b[addr[7:0]] : shadow_color_a[addr[7:0]];
        end else if (addr[15:13] == `XV_REGION_TILE) begin
            word = shadow_tile[addr[9:0]];
        end else if (addr[15:13] == `XV_REGION_COPPER) begin
            word = addr[0] ? shadow_copp_odd[addr[8:1]] : shadow_copp_even[addr[8:1]];
        end
        return word;
    endfunction

    task automatic store_shadow(input logic [15:0] addr, input xr_word_t data);
        if (addr[15:13] == `XV_REGION_COLOR) begin
            if (addr[8]) begin
                shadow_color_b[addr[7:0]] = data;
            end else begin
                shadow_color_a[addr[7:0]] = data;
            end
        end else if (addr[15:13] == `XV_REGION_TILE) begin
            shadow_tile[addr[9:0]] = data;
        end else if (addr[15:13] == `XV_REGION_COPPER) begin
            if (addr[0]) begin
                shadow_copp_odd[addr[8:1]] = data;
            end else begin
                shadow_copp_even[addr[8:1]] = data;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic host_request(input logic wr, input logic [15:0] addr, input xr_word_t data);
        @(posedge clk);
        #2;
        xr_sel_i  = 1'b1;
        xr_wr_i   = wr;
        xr_addr_i = addr;
        xr_data_i = data;
    endtask

    task automatic host_release();
        @(posedge clk);
        #2;
        xr_sel_i = 1'b0;
        xr_wr_i  = 1'b0;
    endtask

    // data is taken in the same cycle as the ack
    task automatic wait_host_ack(input string what, output xr_word_t data);
        int   cycles;
        logic acked;
        acked = 1'b0;
        for (cycles = 0; cycles < 50 && !acked; cycles++) begin
            @(negedge clk);
            acked = xr_ack_o;
        end
        data = xr_data_o;
        if (!acked) begin
            $display("timeout, no host acknowledge for %s within 50 cycles", what);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic host_write(input logic [15:0] addr, input xr_word_t data);
        xr_word_t unused_word;
        host_request(1'b1, addr, data);
        wait_host_ack("host write", unused_word);
        host_release();
        store_shadow(addr, data);
    endtask

    task automatic host_read(input logic [15:0] addr, output xr_word_t data);
        host_request(1'b0, addr, 16'h0000);
        wait_host_ack("host read", data);
        host_release();
    endtask

    task automatic test_reset();
        int errs_before;
        errs_before = errors;
        @(negedge clk);
        check_value("reset xr_ack_o", 32'h0, 32'(xr_ack_o));
        check_value("reset copp_xr_ack_o", 32'h0, 32'(copp_xr_ack_o));
        check_value("reset xreg_wr_o", 32'h0, 32'(xreg_wr_o));
        report_test("reset", errs_before);
    endtask

    task automatic test_round_trip();
        int          errs_before;
        int          k;
        logic [31:0] rnd;
        logic [15:0] addr;
        xr_word_t    rdata;
        errs_before = errors;
        // every target in turn, random word and data
        for (k = 0; k < 10 && !timed_out; k++) begin
            rnd = $urandom();
            case (k % 5)
                0: addr = {`XV_REGION_COLOR, 4'h0, 1'b0, rnd[7:0]};
                1: addr = {`XV_REGION_COLOR, 4'h0, 1'b1, rnd[7:0]};
                2: addr = {`XV_REGION_TILE, 3'h0, rnd[9:0]};
                3: addr = {`XV_REGION_COPPER, 4'h0, rnd[7:0], 1'b0};
                default: addr = {`XV_REGION_COPPER, 4'h0, rnd[7:0], 1'b1};
            endcase
            host_write(addr, rnd[31:16]);
            host_read(addr, rdata);
            check_value($sformatf("round trip %h", addr), 32'(expected_word(addr)), 32'(rdata));
        end
        report_test("host_round_trip", errs_before);
    endtask

    task automatic test_copper_priority();
        int          errs_before;
        int          cycle;
        int          copp_cycle;
        int          host_cycle;
        logic [15:0] copp_addr;
        logic [15:0] host_addr;
        xr_word_t    copp_data;
        xr_word_t    host_data;
        xr_word_t    rdata;
        errs_before = errors;
        copp_addr   = {`XV_REGION_TILE, 3'h0, 10'h155};
        host_addr   = {`XV_REGION_COLOR, 4'h0, 1'b0, 8'h44};
        copp_data   = 16'($urandom());
        host_data   = 16'($urandom());
        copp_cycle  = -1;
        host_cycle  = -1;
        @(posedge clk);
        #2;
        copp_xr_sel_i  = 1'b1;
        copp_xr_addr_i = copp_addr;
        copp_xr_data_i = copp_data;
        xr_sel_i       = 1'b1;
        xr_wr_i        = 1'b1;
        xr_addr_i      = host_addr;
        xr_data_i      = host_data;
        // each requester lets go right after its ack cycle
        for (cycle = 0; cycle < 50 && (copp_cycle < 0 || host_cycle < 0); cycle++) begin
            @(negedge clk);
            if (copp_xr_ack_o && copp_cycle < 0) begin
                copp_cycle = cycle;
            end
            if (xr_ack_o && host_cycle < 0) begin
                host_cycle = cycle;
            end
            @(posedge clk);
            #2;
            if (copp_cycle >= 0) begin
                copp_xr_sel_i = 1'b0;
            end
            if (host_cycle >= 0) begin
                xr_sel_i = 1'b0;
                xr_wr_i  = 1'b0;
            end
        end
        if (copp_cycle < 0 || host_cycle < 0) begin
            $display("timeout, copper and host writes not both acknowledged in 50 cycles");
            errors++;
            timed_out = 1'b1;
        end else begin
            assert (copp_cycle < host_cycle)
            else begin
                $display("copper acknowledge did not come before the host acknowledge");
                errors++;
            end
            store_shadow(copp_addr, copp_data);
            store_shadow(host_addr, host_data);
            host_read(copp_addr, rdata);
            check_value("copper write landed", 32'(expected_word(copp_addr)), 32'(rdata));
            host_read(host_addr, rdata);
            check_value("host write landed", 32'(expected_word(host_addr)), 32'(rdata));
        end
        report_test("copper_priority", errs_before);
    endtask

    task automatic test_video_reads();
        int          errs_before;
        logic [15:0] tile_addr;
        xr_word_t    rdata;
        errs_before = errors;
        tile_addr   = {`XV_REGION_TILE, 3'h0, 10'h2a7};
        host_write({`XV_REGION_COLOR, 4'h0, 1'b0, 8'h21}, 16'($urandom()));
        host_write({`XV_REGION_COLOR, 4'h0, 1'b1, 8'h5c}, 16'($urandom()));
        host_write(tile_addr, 16'($urandom()));
        host_write({`XV_REGION_COPPER, 4'h0, 8'h13, 1'b0}, 16'($urandom()));
        host_write({`XV_REGION_COPPER, 4'h0, 8'h13, 1'b1}, 16'($urandom()));
        @(posedge clk);
        #2;
        vgen_color_sel_i    = 1'b1;
        vgen_color_a_addr_i = 8'h21;
        vgen_color_b_addr_i = 8'h5c;
        vgen_tile_sel_i     = 1'b1;
        vgen_tile_addr_i    = 10'h2a7;
        copp_prog_sel_i     = 1'b1;
        copp_prog_addr_i    = 8'h13;
        @(posedge clk);
        #2;
        vgen_color_sel_i = 1'b0;
        vgen_tile_sel_i  = 1'b0;
        copp_prog_sel_i  = 1'b0;
        @(negedge clk);
        check_value("video color a", 32'(shadow_color_a[8'h21]), 32'(vgen_color_a_data_o));
        check_value("video color b", 32'(shadow_color_b[8'h5c]), 32'(vgen_color_b_data_o));
        check_value("video tile", 32'(shadow_tile[10'h2a7]), 32'(vgen_tile_data_o));
        check_value("copper fetch", {shadow_copp_even[8'h13], shadow_copp_odd[8'h13]},
                    copp_prog_data_o);
        // host tile read held off by the video select
        host_request(1'b0, tile_addr, 16'h0000);
        vgen_tile_sel_i  = 1'b1;
        vgen_tile_addr_i = 10'h001;
        repeat (4) begin
            @(negedge clk);
            check_value("host tile read held off", 32'h0, 32'(xr_ack_o));
        end
        @(posedge clk);
        #2;
        vgen_tile_sel_i = 1'b0;
        wait_host_ack("host tile read after video", rdata);
        host_release();
        check_value("host tile read after video", 32'(expected_word(tile_addr)), 32'(rdata));
        report_test("video_reads", errs_before);
    endtask

    task automatic test_register_bus();
        int       errs_before;
        xr_word_t wdata;
        xr_word_t rdata;
        errs_before = errors;
        wdata       = 16'($urandom());
        host_request(1'b1, 16'h0012, wdata);
        @(negedge clk);
        check_value("xreg_wr_o", 32'h1, 32'(xreg_wr_o));
        check_value("xreg_addr_o", 32'h0012, 32'(xreg_addr_o));
        check_value("xreg_data_o", 32'(wdata), 32'(xreg_data_o));
        wait_host_ack("register write", rdata);
        host_release();
        host_read(16'h0012, rdata);
        check_value("register read back", 32'(wdata), 32'(rdata));
        host_read(16'h0034, rdata);
        check_value("register read fill", 32'(reg_fill(8'h34)), 32'(rdata));
        report_test("register_bus", errs_before);
    endtask

    task automatic test_unmapped();
        int       errs_before;
        xr_word_t rdata;
        errs_before = errors;
        host_request(1'b1, 16'hE000, 16'($urandom()));
        @(negedge clk);
        check_value("unmapped xreg_wr_o", 32'h0, 32'(xreg_wr_o));
        wait_host_ack("unmapped write", rdata);
        host_release();
        host_read(16'hE000, rdata);
        check_value("unmapped read", 32'h0, 32'(rdata));
        report_test("unmapped", errs_before);
    endtask

    initial begin
        int seed_word;
        int i;
        seed_word = $urandom(77149);
        rst_i = 1'b1;
        // unmapped requests held through reset so the ack registers see live grants
        xr_sel_i = 1'b1;
        xr_wr_i = 1'b0;
        xr_addr_i = 16'hE000;
        xr_data_i = 16'h0000;
        copp_xr_sel_i = 1'b1;
        copp_xr_addr_i = 16'hE000;
        copp_xr_data_i = 16'h0000;
        vgen_color_sel_i = 1'b0;
        vgen_color_a_addr_i = '0;
        vgen_color_b_addr_i = '0;
        vgen_tile_sel_i = 1'b0;
        vgen_tile_addr_i = '0;
        copp_prog_sel_i = 1'b0;
        copp_prog_addr_i = '0;
        shadow_color_a = '{default: '0};
        shadow_color_b = '{default: '0};
        shadow_tile = '{default: '0};
        shadow_copp_even = '{default: '0};
        shadow_copp_odd = '{default: '0};
        for (i = 0; i < 256; i++) begin
            reg_model[i] = reg_fill(i[7:0]);
        end
        repeat (2) @(posedge clk);
        #2;
        rst_i = 1'b0;
        xr_sel_i = 1'b0;
        copp_xr_sel_i = 1'b0;
        test_reset();
        if (!timed_out) test_round_trip();
        if (!timed_out) test_copper_priority();
        if (!timed_out) test_video_reads();
        if (!timed_out) test_register_bus();
        if (!timed_out) test_unmapped();
        $display("summary: %0d tests run, %0d with errors, %0d check errors",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+.
xv_pkg.sv
xr_bus_if.sv
xr_ram.sv
xr_write_arb.sv
xr_read_arb.sv
xrmem_arb.sv
xrmem_top.sv
tb_xrmem_top.sv

// ==== Makefile ====
TOP := tb_xrmem_top

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard *.sv) xv_params.svh
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "all tests passed" sim.log

lint:
	verilator --lint-only -Wall -f project.f --top-module xrmem_top

clean:
	rm -rf obj_dir sim.log
